// ==== logic/alu_config.svh ====
// ALU configuration macros for the data width, the multiplier width and the register map.
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

`define ALU_W 16 // Data and register width.
`define MUL_W 8  // Multiplier operand width.
`define ADR_W 3  // Wishbone word address width.

// Word addresses of the host-visible registers.
`define REG_OPA  3'd0
`define REG_OPB  3'd1
`define REG_CTRL 3'd2
`define REG_STAT 3'd3
`define REG_RES  3'd4
`define REG_REM  3'd5

// Control word bits. Bits 2:0 carry the opcode.
`define CTRL_START_BIT 4
`define CTRL_CLR_BIT   5

`endif

// ==== logic/alu_pkg.sv ====
// ALU package with the opcode and multiplier state types.
package alu_pkg;

  // Opcodes 5 to 7 are reserved and execute as an add.
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_ACC = 3'd2,
    OP_MUL = 3'd3,
    OP_SHR = 3'd4
  } alu_op_e;

  typedef enum logic [1:0] {
    M_IDLE = 2'd0, // Waiting for go.
    M_RUN  = 2'd1, // One shift-add step per clock.
    M_DONE = 2'd2  // Product is held for one cycle.
  } mul_state_e;

endpackage

// ==== logic/cla_adder.sv ====
// Carry look-ahead adder built from 4-bit groups and a second-level carry unit.
`timescale 1ns/10ps
`include "alu_config.svh"

module cla_adder (
  input  logic [`ALU_W-1:0] a,
  input  logic [`ALU_W-1:0] b,
  input  logic              cin,
  output logic [`ALU_W-1:0] sum,
  output logic              cout
);

  localparam int NG = `ALU_W / 4; // Number of 4-bit groups.

  logic [`ALU_W-1:0] p;  // Bit propagate.
  logic [`ALU_W-1:0] g;  // Bit generate.
  logic [`ALU_W-1:0] c;  // Carry into each bit.
  logic [NG-1:0]     gp; // Group propagate.
  logic [NG-1:0]     gg; // Group generate.
  logic [NG-1:0]     gc; // Carry into each group.

  assign p = a ^ b;
  assign g = a & b;

  genvar k;
  generate
    for (k = 0; k < NG; k++)
    begin : g_grp
      logic [3:0] pk;
      logic [3:0] gk;

      assign pk = p[4*k +: 4];
      assign gk = g[4*k +: 4];

      // A group propagates only when every bit does.
      assign gp[k] = &pk;
      assign gg[k] = gk[3]
                   | (pk[3] & gk[2])
                   | (pk[3] & pk[2] & gk[1])
                   | (pk[3] & pk[2] & pk[1] & gk[0]);

      // Each group resolves its inner carries from its own carry in.
      assign c[4*k]   = gc[k];
      assign c[4*k+1] = gk[0] | (pk[0] & gc[k]);
      assign c[4*k+2] = gk[1] | (pk[1] & gk[0]) | (pk[1] & pk[0] & gc[k]);
      assign c[4*k+3] = gk[2]
                      | (pk[2] & gk[1])
                      | (pk[2] & pk[1] & gk[0])
                      | (pk[2] & pk[1] & pk[0] & gc[k]);
    end
  endgenerate

  // Second level computes the four group carries in parallel.
  assign gc[0] = cin;
  assign gc[1] = gg[0] | (gp[0] & cin);
  assign gc[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & cin);
  assign gc[3] = gg[2]
               | (gp[2] & gg[1])
               | (gp[2] & gp[1] & gg[0])
               | (gp[2] & gp[1] & gp[0] & cin);

  assign cout = gg[3]
              | (gp[3] & gg[2])
              | (gp[3] & gp[2] & gg[1])
              | (gp[3] & gp[2] & gp[1] & gg[0])
              | (gp[3] & gp[2] & gp[1] & gp[0] & cin);

  assign sum = p ^ c;

endmodule

// ==== logic/shift_mul.sv ====
// Sequential shift-add multiplier that adds one partial product per clock.
`timescale 1ns/10ps
`include "alu_config.svh"

module shift_mul (
  input  logic              C,
  input  logic              CLR,
  input  logic              go,
  input  logic [`MUL_W-1:0] a,
  input  logic [`MUL_W-1:0] b,
  output logic [`ALU_W-1:0] product,
  output logic              done
);

  localparam int CNT_W = $clog2(`MUL_W + 1);

  alu_pkg::mul_state_e state;
  logic [CNT_W-1:0]    step;    // Steps taken in the current run.
  logic [`ALU_W-1:0]   mcand;   // Multiplicand, shifted left each step.
  logic [`MUL_W-1:0]   mplier;  // Multiplier, shifted right each step.
  logic [`ALU_W-1:0]   partial; // Running partial product.
  logic [`ALU_W-1:0]   addend;
  logic [`ALU_W-1:0]   psum;
  logic                last;

  assign addend = mplier[0] ? mcand : '0;
  assign last   = (step == CNT_W'(`MUL_W - 1));
  assign done   = (state == alu_pkg::M_DONE);

  cla_adder u_add (
    .a    (partial),
    .b    (addend),
    .cin  (1'b0),
    .sum  (psum),
    .cout ()
  );

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
    begin
      state <= alu_pkg::M_IDLE;
      step  <= '0;
    end
    else
    begin
      case (state)
        alu_pkg::M_IDLE:
        begin
          if (go)
          begin
            state <= alu_pkg::M_RUN;
            step  <= '0;
          end
        end
        alu_pkg::M_RUN:
        begin
          step <= step + 1'b1;
          if (last)
            state <= alu_pkg::M_DONE;
        end
        default: state <= alu_pkg::M_IDLE; // M_DONE lasts one cycle.
      endcase
    end
  end

  always_ff @(posedge C)
  begin
    if (go && state == alu_pkg::M_IDLE)
    begin
      mcand   <= {{(`ALU_W-`MUL_W){1'b0}}, a};
      mplier  <= b;
      partial <= '0;
    end
    else if (state == alu_pkg::M_RUN)
    begin
      partial <= psum;
      mcand   <= mcand << 1;
      mplier  <= mplier >> 1;
      if (last)
        product <= psum; // Final sum is held while done is high.
    end
  end

  a_step_bound: assert property (@(posedge C) disable iff (CLR) step <= CNT_W'(`MUL_W))
    else $error("shift_mul step counter passed MUL_W");

  // The core must hold go back while a product is being formed.
  a_go_idle: assert property (@(posedge C) disable iff (CLR) go |-> state == alu_pkg::M_IDLE)
    else $error("shift_mul go outside M_IDLE");

endmodule

// ==== logic/alu_core.sv ====
// ALU core that runs each operation and holds the accumulator, result and status flags.
`timescale 1ns/10ps
`include "alu_config.svh"

module alu_core (
  input  logic              C,
  input  logic              CLR,
  input  logic [`ALU_W-1:0] opa,
  input  logic [`ALU_W-1:0] opb,
  input  alu_pkg::alu_op_e  op,
  input  logic              start,
  input  logic              acc_clear,
  input  logic              ctrl_write,
  output logic [`ALU_W-1:0] result,
  output logic [`ALU_W-1:0] remainder,
  output logic              busy,
  output logic              carry,
  output logic              zero,
  output logic              overrun,
  output logic              done
);

  localparam int SH_W = $clog2(`ALU_W);

  logic [`ALU_W-1:0] acc;
  logic [`ALU_W-1:0] acc_base;
  logic [`ALU_W-1:0] add_x;
  logic [`ALU_W-1:0] add_y;
  logic [`ALU_W-1:0] add_sum;
  logic              add_cin;
  logic              add_cout;
  logic [SH_W-1:0]   shamt;
  logic [`ALU_W-1:0] nxt_res;
  logic [`ALU_W-1:0] nxt_rem;
  logic              nxt_carry;
  logic              accept;
  logic              mul_go;
  logic              mul_done;
  logic [`ALU_W-1:0] product;

  assign accept   = start && !busy;  // A start while busy is dropped.
  assign mul_go   = accept && (op == alu_pkg::OP_MUL);
  assign acc_base = acc_clear ? '0 : acc; // Clear wins over a same-cycle add.
  assign shamt    = opb[SH_W-1:0];

  // One adder serves ADD, SUB and ACC.
  always_comb
  begin
    add_x   = opa;
    add_y   = opb;
    add_cin = 1'b0;
    case (op)
      alu_pkg::OP_SUB:
      begin
        add_y   = ~opb;
        add_cin = 1'b1;
      end
      alu_pkg::OP_ACC:
      begin
        add_x = acc_base;
        add_y = opa;
      end
      default: ; // Add and the reserved codes.
    endcase
  end

  cla_adder u_add (.a(add_x), .b(add_y), .cin(add_cin), .sum(add_sum), .cout(add_cout));

  shift_mul u_mul (
    .C       (C),
    .CLR     (CLR),
    .go      (mul_go),
    .a       (opa[`MUL_W-1:0]),
    .b       (opb[`MUL_W-1:0]),
    .product (product),
    .done    (mul_done)
  );

  always_comb
  begin
    nxt_res   = add_sum;
    nxt_rem   = '0;
    nxt_carry = add_cout;
    if (op == alu_pkg::OP_SHR)
    begin
      nxt_res   = opa >> shamt;
      nxt_rem   = opa & ~({`ALU_W{1'b1}} << shamt); // Bits shifted out.
      nxt_carry = 1'b0;
    end
  end

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
    begin
      acc       <= '0;
      result    <= '0;
      remainder <= '0;
      carry     <= 1'b0;
      zero      <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      overrun   <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (accept && op == alu_pkg::OP_ACC)
        acc <= add_sum;
      else if (acc_clear)
        acc <= '0;
      if (mul_go)
        busy <= 1'b1;
      else if (busy && done)
        busy <= 1'b0; // Falls together with done.
      if (accept && op != alu_pkg::OP_MUL)
      begin
        result    <= nxt_res;
        remainder <= nxt_rem;
        carry     <= nxt_carry;
        zero      <= (nxt_res == '0);
        done      <= 1'b1;
      end
      else if (mul_done)
      begin
        result    <= product;
        remainder <= '0;
        carry     <= 1'b0;
        zero      <= (product == '0);
        done      <= 1'b1;
      end
      // Setting wins since the dropped start arrives with its own control write.
      if (start && busy)
        overrun <= 1'b1;
      else if (ctrl_write)
        overrun <= 1'b0;
    end
  end

  a_done_busy: assert property (@(posedge C) disable iff (CLR) (done && busy) |=> !busy)
    else $error("alu_core done and busy overlap outside the final cycle");

  a_overrun: assert property (@(posedge C) disable iff (CLR)
                              $rose(overrun) |-> $past(start && busy))
    else $error("alu_core overrun set without a start while busy");

endmodule

// ==== logic/alu_regs.sv ====
// Wishbone classic slave register block that feeds the ALU core and returns its results.
`timescale 1ns/10ps
`include "alu_config.svh"

module alu_regs (
  input  logic              C,
  input  logic              CLR,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [`ADR_W-1:0] wb_adr,
  input  logic [`ALU_W-1:0] wb_dat_w,
  output logic [`ALU_W-1:0] wb_dat_r,
  output logic              wb_ack,
  output logic [`ALU_W-1:0] opa,
  output logic [`ALU_W-1:0] opb,
  output alu_pkg::alu_op_e  op,
  output logic              start,
  output logic              acc_clear,
  output logic              ctrl_write,
  input  logic [`ALU_W-1:0] result,
  input  logic [`ALU_W-1:0] remainder,
  input  logic              busy,
  input  logic              carry,
  input  logic              zero,
  input  logic              overrun
);

  logic              req;
  logic              wr_ctrl;
  logic [`ALU_W-1:0] ctrl_word;
  logic [`ALU_W-1:0] stat_word;
  logic [`ALU_W-1:0] rd_mux;

  // A new request is one not yet acknowledged.
  assign req       = wb_cyc && wb_stb && !wb_ack;
  assign wr_ctrl   = req && wb_we && (wb_adr == `REG_CTRL);
  assign ctrl_word = {{(`ALU_W-3){1'b0}}, op}; // Start and clear read back as zero.
  assign stat_word = {{(`ALU_W-4){1'b0}}, overrun, zero, carry, busy};

  always_comb
  begin
    case (wb_adr)
      `REG_OPA:  rd_mux = opa;
      `REG_OPB:  rd_mux = opb;
      `REG_CTRL: rd_mux = ctrl_word;
      `REG_STAT: rd_mux = stat_word;
      `REG_RES:  rd_mux = result;
      `REG_REM:  rd_mux = remainder;
      default:   rd_mux = '0;
    endcase
  end

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
    begin
      wb_ack     <= 1'b0;
      opa        <= '0;
      opb        <= '0;
      op         <= alu_pkg::OP_ADD;
      start      <= 1'b0;
      acc_clear  <= 1'b0;
      ctrl_write <= 1'b0;
    end
    else
    begin
      wb_ack     <= req;
      start      <= wr_ctrl && wb_dat_w[`CTRL_START_BIT];
      acc_clear  <= wr_ctrl && wb_dat_w[`CTRL_CLR_BIT];
      ctrl_write <= wr_ctrl;
      if (req && wb_we && wb_adr == `REG_OPA)
        opa <= wb_dat_w;
      if (req && wb_we && wb_adr == `REG_OPB)
        opb <= wb_dat_w;
      if (wr_ctrl)
        op <= alu_pkg::alu_op_e'(wb_dat_w[2:0]);
    end
  end

  // Read data is captured on the ack edge.
  always_ff @(posedge C)
  begin
    if (req)
      wb_dat_r <= rd_mux;
  end

  a_ack_req: assert property (@(posedge C) disable iff (CLR)
                              $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else $error("alu_regs ack without a request");

  a_ack_once: assert property (@(posedge C) disable iff (CLR) wb_ack |=> !wb_ack)
    else $error("alu_regs ack held for two cycles");

endmodule

// ==== logic/alu_top.sv ====
// Top level of the memory-mapped ALU with the register block beside the core.
`timescale 1ns/10ps
`include "alu_config.svh"

module alu_top (
  input  logic              C,
  input  logic              CLR,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [`ADR_W-1:0] wb_adr,
  input  logic [`ALU_W-1:0] wb_dat_w,
  output logic [`ALU_W-1:0] wb_dat_r,
  output logic              wb_ack,
  output logic              done
);

  logic [`ALU_W-1:0] opa;
  logic [`ALU_W-1:0] opb;
  alu_pkg::alu_op_e  op;
  logic              start;
  logic              acc_clear;
  logic              ctrl_write;
  logic [`ALU_W-1:0] result;
  logic [`ALU_W-1:0] remainder;
  logic              busy;
  logic              carry;
  logic              zero;
  logic              overrun;

  alu_regs u_regs (
    .C (C), .CLR (CLR),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
    .opa (opa), .opb (opb), .op (op),
    .start (start), .acc_clear (acc_clear), .ctrl_write (ctrl_write),
    .result (result), .remainder (remainder),
    .busy (busy), .carry (carry), .zero (zero), .overrun (overrun)
  );

  alu_core u_core (
    .C (C), .CLR (CLR),
    .opa (opa), .opb (opb), .op (op),
    .start (start), .acc_clear (acc_clear), .ctrl_write (ctrl_write),
    .result (result), .remainder (remainder),
    .busy (busy), .carry (carry), .zero (zero), .overrun (overrun),
    .done (done)
  );

endmodule

// ==== verif/alu_tb.sv ====
// Testbench for the memory-mapped ALU that drives the Wishbone port and checks each operation.
`timescale 1ns/10ps
`include "alu_config.svh"

module alu_tb;

  localparam int W           = `ALU_W;
  localparam int AW          = `ADR_W;
  localparam int WATCHDOG_NS = 200 * (`MUL_W + 12) * 4; // Budget per operation times count.

  logic          C;
  logic          CLR;
  logic          wb_cyc;
  logic          wb_stb;
  logic          wb_we;
  logic [AW-1:0] wb_adr;
  logic [W-1:0]  wb_dat_w;
  logic [W-1:0]  wb_dat_r;
  logic          wb_ack;
  logic          done;

  logic [31:0]   lfsr;
  logic [W-1:0]  acc_model;     // Expected accumulator contents.
  logic          chk_timing;    // Low while a start is meant to be dropped.
  logic          ctrl_go;
  logic          is_mul;
  int            val_errs;
  int            sva_errs;
  int            to_errs;
  int            done_count;
  int            done_expected;

  alu_top UUT (
    .C (C), .CLR (CLR),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
    .done (done)
  );

  always #2 C = ~C;

  always @(posedge C)
  begin
    if (!CLR && done)
      done_count <= done_count + 1;
  end

  // A new control write with the start bit, seen in its request cycle.
  assign ctrl_go = wb_cyc && wb_stb && wb_we && !wb_ack && (wb_adr == `REG_CTRL)
                 && wb_dat_w[`CTRL_START_BIT] && chk_timing;
  assign is_mul  = (wb_dat_w[2:0] == alu_pkg::OP_MUL);

  a_ack_next: assert property (@(posedge C) disable iff (CLR)
                               (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
    else
    begin
      sva_errs++;
      $display("a bus request was not acknowledged on the next edge");
    end

  a_ack_once: assert property (@(posedge C) disable iff (CLR) wb_ack |=> !wb_ack)
    else
    begin
      sva_errs++;
      $display("ack stayed high for two cycles");
    end

  a_ack_cause: assert property (@(posedge C) disable iff (CLR)
                                wb_ack |-> $past(wb_cyc && wb_stb))
    else
    begin
      sva_errs++;
      $display("ack came without a bus request");
    end

  a_done_pulse: assert property (@(posedge C) disable iff (CLR) done |=> !done)
    else
    begin
      sva_errs++;
      $display("done stayed high for more than one cycle");
    end

  // Start leaves on the ack edge and done follows one cycle later.
  a_single: assert property (@(posedge C) disable iff (CLR)
                             (ctrl_go && !is_mul) |=> !done ##1 done ##1 !done)
    else
    begin
      sva_errs++;
      $display("single-cycle operation did not pulse done one cycle after start");
    end

  a_mul: assert property (@(posedge C) disable iff (CLR)
                          (ctrl_go && is_mul) |=> !UUT.busy
                          ##1 (UUT.busy && !done) [*(`MUL_W + 1)]
                          ##1 (UUT.busy && done) ##1 !(UUT.busy || done))
    else
    begin
      sva_errs++;
      $display("multiply busy and done timing does not match MUL_W plus 2 cycles");
    end

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken.
  function automatic logic [W-1:0] rand_bits(input int n);
    logic [W-1:0] v;
    logic         fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[W-2:0], fb};
    end
    return v;
  endfunction

  function automatic logic [W-1:0] ctrl_val(input logic [2:0] op, input logic st,
                                            input logic clr);
    return (W'(clr) << `CTRL_CLR_BIT) | (W'(st) << `CTRL_START_BIT) | W'(op);
  endfunction

  task automatic check(input string name, input logic [W-1:0] exp, input logic [W-1:0] act);
    assert (act === exp)
    else
    begin
      val_errs++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic bus_cycle(input logic we, input logic [AW-1:0] adr,
                           input logic [W-1:0] wdat, output logic [W-1:0] rdat);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    waited   = 0;
    do
    begin
      @(negedge C);
      waited++;
    end while (!wb_ack && waited < 4);
    if (!wb_ack)
    begin
      to_errs++;
      $display("no ack for the bus cycle to address %0d", adr);
    end
    rdat   = wb_dat_r; // Valid while ack is high.
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge C);
  endtask

  task automatic bus_write(input logic [AW-1:0] adr, input logic [W-1:0] data);
    logic [W-1:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic bus_read(input logic [AW-1:0] adr, output logic [W-1:0] data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  task automatic wait_done(input string name);
    int waited;
    waited = 0;
    while (!done && waited < `MUL_W + 8)
    begin
      @(negedge C);
      waited++;
    end
    if (!done)
    begin
      to_errs++;
      $display("done never came in test %s", name);
    end
  endtask

  // Expected result, remainder and carry from the opcode rules.
  task automatic predict(input logic [2:0] op, input logic [W-1:0] a, input logic [W-1:0] b,
                         input logic clr, output logic [W-1:0] res,
                         output logic [W-1:0] rem, output logic cy);
    logic [W:0] wide;
    if (clr)
      acc_model = '0;
    wide = {1'b0, a} + {1'b0, b}; // Add and the reserved codes.
    rem  = '0;
    case (op)
      alu_pkg::OP_SUB: wide = {1'b0, a} + {1'b0, ~b} + 1'b1;
      alu_pkg::OP_ACC:
      begin
        wide      = {1'b0, acc_model} + {1'b0, a};
        acc_model = wide[W-1:0];
      end
      alu_pkg::OP_MUL: wide = {1'b0, W'(a[`MUL_W-1:0]) * W'(b[`MUL_W-1:0])};
      alu_pkg::OP_SHR:
      begin
        wide = {1'b0, a / (W'(1) << b[3:0])};
        rem  = a % (W'(1) << b[3:0]);
      end
      default: ;
    endcase
    res = wide[W-1:0];
    cy  = wide[W];
  endtask

  task automatic run_op(input string name, input logic [2:0] op, input logic [W-1:0] a,
                        input logic [W-1:0] b, input logic clr);
    logic [W-1:0] exp_res;
    logic [W-1:0] exp_rem;
    logic         exp_cy;
    logic [W-1:0] rd;
    predict(op, a, b, clr, exp_res, exp_rem, exp_cy);
    bus_write(`REG_OPA, a);
    bus_write(`REG_OPB, b);
    bus_write(`REG_CTRL, ctrl_val(op, 1'b1, clr));
    done_expected++;
    wait_done(name);
    bus_read(`REG_RES, rd);
    check({name, " result"}, exp_res, rd);
    bus_read(`REG_REM, rd);
    check({name, " remainder"}, exp_rem, rd);
    bus_read(`REG_STAT, rd); // Busy has fallen by now.
    check({name, " status"}, {{(W-4){1'b0}}, 1'b0, (exp_res == '0), exp_cy, 1'b0}, rd);
  endtask

  initial
  begin : stim
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] rd;
    logic [W-1:0] exp_res;
    logic [W-1:0] exp_rem;
    logic         exp_cy;
    C             = 1'b0;
    CLR           = 1'b1;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    lfsr          = 32'h0a8d_2542;
    acc_model     = '0;
    chk_timing    = 1'b1;
    val_errs      = 0;
    sva_errs      = 0;
    to_errs       = 0;
    done_count    = 0;
    done_expected = 0;
    repeat (16) @(posedge C);
    @(negedge C);
    CLR = 1'b0;

    check("reset ack", '0, W'(wb_ack));
    check("reset done", '0, W'(done));
    for (int k = 0; k < 8; k++)
    begin
      bus_read(AW'(k), rd); // Unused addresses read zero as well.
      check($sformatf("reset read %0d", k), '0, rd);
    end
    a = rand_bits(W);
    b = rand_bits(W);
    bus_write(`REG_OPA, a);
    bus_write(`REG_OPB, b);
    bus_read(`REG_OPA, rd);
    check("opa readback", a, rd);
    bus_read(`REG_OPB, rd);
    check("opb readback", b, rd);
    bus_write(`REG_RES, 16'hffff);
    bus_read(`REG_RES, rd);
    check("result write ignored", '0, rd);
    bus_write(AW'(6), 16'hffff);
    bus_read(AW'(6), rd);
    check("unused write ignored", '0, rd);

    for (int i = 0; i < 60; i++)
    begin
      a = rand_bits(W);
      b = rand_bits(W);
      if (i % 2)
        run_op("sub", alu_pkg::OP_SUB, a, b, 1'b0);
      else
        run_op("add", alu_pkg::OP_ADD, a, b, 1'b0);
    end
    run_op("add all ones", alu_pkg::OP_ADD, 16'hffff, 16'h0001, 1'b0);
    run_op("sub zero", alu_pkg::OP_SUB, 16'h0000, 16'h0001, 1'b0);

    bus_write(`REG_CTRL, ctrl_val(alu_pkg::OP_ACC, 1'b0, 1'b1)); // Clear only.
    acc_model = '0;
    for (int i = 0; i < 20; i++)
    begin
      a = rand_bits(W);
      run_op("acc", alu_pkg::OP_ACC, a, '0, 1'b0);
    end
    a = rand_bits(W);
    run_op("acc clear add", alu_pkg::OP_ACC, a, '0, 1'b1);

    for (int i = 0; i < 60; i++)
    begin
      a = rand_bits(W);
      b = rand_bits(W);
      run_op("mul", alu_pkg::OP_MUL, a, b, 1'b0);
    end

    for (int n = 0; n < 16; n++)
    begin
      a = rand_bits(W);
      b = (rand_bits(W - 4) << 4) | W'(n); // Upper bits of B are not part of the shift.
      run_op($sformatf("shr %0d", n), alu_pkg::OP_SHR, a, b, 1'b0);
    end

    // A second start lands while the multiplier is busy.
    a = rand_bits(W);
    b = rand_bits(W) | W'(1); // An odd multiplier makes a new A change the product.
    predict(alu_pkg::OP_MUL, a, b, 1'b0, exp_res, exp_rem, exp_cy);
    bus_write(`REG_OPA, a);
    bus_write(`REG_OPB, b);
    bus_write(`REG_CTRL, ctrl_val(alu_pkg::OP_MUL, 1'b1, 1'b0));
    done_expected++;
    bus_write(`REG_OPA, ~a); // The dropped start would multiply this operand.
    chk_timing = 1'b0;
    bus_write(`REG_CTRL, ctrl_val(alu_pkg::OP_MUL, 1'b1, 1'b0));
    chk_timing = 1'b1;
    wait_done("overrun");
    bus_read(`REG_RES, rd);
    check("overrun product", exp_res, rd);
    bus_read(`REG_STAT, rd);
    check("overrun status", {{(W-4){1'b0}}, 1'b1, (exp_res == '0), 2'b00}, rd);
    bus_write(`REG_CTRL, ctrl_val(alu_pkg::OP_MUL, 1'b0, 1'b0));
    bus_read(`REG_STAT, rd);
    check("overrun cleared", {{(W-4){1'b0}}, 1'b0, (exp_res == '0), 2'b00}, rd);

    repeat (4) @(negedge C);
    check("done count", W'(done_expected), W'(done_count));
    $display("errors: value %0d, assertion %0d, timeout %0d", val_errs, sva_errs, to_errs);
    if (val_errs + sva_errs + to_errs == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("errors: value %0d, assertion %0d, timeout %0d", val_errs, sva_errs, to_errs);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+logic
logic/alu_pkg.sv
logic/cla_adder.sv
logic/shift_mul.sv
logic/alu_core.sv
logic/alu_regs.sv
logic/alu_top.sv
verif/alu_tb.sv
